// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

  localparam int xlen = 32;
  localparam logic [xlen-1:0] reset_pc = '0;

  // packet slots in the decode queue.
  localparam int fetch_credits = 4;
  localparam int credit_width = $clog2(fetch_credits + 1);

  // one btac set per 8-byte fetch block.
  localparam int btac_entries = 16;
  localparam int btac_index_bits = $clog2(btac_entries);
  localparam int btac_tag_bits = xlen - 3 - btac_index_bits;

  localparam logic csr_sel_tvec = 1'b0;
  localparam logic csr_sel_epc = 1'b1;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic            taken;
    logic [xlen-1:0] target;
    logic            mispredict;
    logic [xlen-1:0] redirect_addr;
  } exec_resolve_type;

  typedef struct packed {
    logic            taken;
    logic [xlen-1:0] target;
  } btac_out_type;

  typedef struct packed {
    logic            valid;
    logic            sel;
    logic [xlen-1:0] data;
  } csr_cfg_type;

  typedef struct packed {
    logic            trap;
    logic            mret;
    logic [xlen-1:0] target;
  } redirect_type;

  typedef struct packed {
    logic            valid;
    logic [xlen-1:0] pc;
    logic [31:0]     instr0;
    logic [31:0]     instr1;
  } fetch_packet_type;

endpackage

`default_nettype wire

// File: hw/mem_pkg.sv
`default_nettype none

package mem_pkg;

  localparam int itim_depth_words = 256;
  localparam int itim_index_bits = $clog2(itim_depth_words);
  localparam int itim_addr_width = 32;
  localparam int itim_data_width = 64;

  typedef struct packed {
    logic                       valid;
    logic [itim_addr_width-1:0] addr;
  } itim_req_type;

  typedef struct packed {
    logic                       ready;
    logic [itim_data_width-1:0] rdata;
  } itim_rsp_type;

  // program load writes whole 64-bit words.
  typedef struct packed {
    logic                       valid;
    logic [itim_index_bits-1:0] index;
    logic [itim_data_width-1:0] data;
  } itim_load_type;

endpackage

`default_nettype wire

// File: hw/btac.sv
`timescale 1ns/1ns
`default_nettype none

module btac import core_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  logic [xlen-1:0]  lookup_pc,
  output btac_out_type     btac_out,
  input  exec_resolve_type resolve
);

  // slot records which word of the block holds the branch.
  typedef struct packed {
    logic [btac_tag_bits-1:0] tag;
    logic                     slot;
    logic [xlen-1:0]          target;
  } btac_entry_type;

  btac_entry_type            entries [btac_entries];
  logic [btac_entries-1:0]   valid_bits;

  logic [btac_index_bits-1:0] lu_index;
  logic [btac_tag_bits-1:0]   lu_tag;
  btac_entry_type             lu_entry;
  logic                       lu_match;
  logic                       hit0;
  logic                       hit1;

  logic [btac_index_bits-1:0] upd_index;
  logic [btac_tag_bits-1:0]   upd_tag;
  logic                       upd_match;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // lookup for both words of the fetch block.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    lu_index = lookup_pc[3 +: btac_index_bits];
    lu_tag = lookup_pc[xlen-1 -: btac_tag_bits];
    lu_entry = entries[lu_index];
    lu_match = valid_bits[lu_index] & (lu_entry.tag == lu_tag);
    // a branch in word 0 is behind us when fetch starts at word 1.
    hit0 = lu_match & ~lu_entry.slot & ~lookup_pc[2];
    hit1 = lu_match & lu_entry.slot;
    btac_out.taken = hit0 | hit1;
    btac_out.target = lu_entry.target;
  end

  always_comb begin
    upd_index = resolve.pc[3 +: btac_index_bits];
    upd_tag = resolve.pc[xlen-1 -: btac_tag_bits];
    upd_match = valid_bits[upd_index] & (entries[upd_index].tag == upd_tag) &
                (entries[upd_index].slot == resolve.pc[2]);
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      valid_bits <= '0;
    end else if (resolve.valid) begin
      if (resolve.taken) begin
        valid_bits[upd_index] <= 1'b1;
      end else if (upd_match) begin
        valid_bits[upd_index] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (resolve.valid && resolve.taken) begin
      entries[upd_index] <= '{tag: upd_tag, slot: resolve.pc[2], target: resolve.target};
    end
  end

  update_aligned: assert property (@(posedge clock) disable iff (!reset)
    resolve.valid |-> resolve.pc[1:0] == 2'b00);

endmodule

`default_nettype wire

// File: hw/itim.sv
`timescale 1ns/1ns
`default_nettype none

module itim import mem_pkg::*; (
  input  logic          clock,
  input  logic          reset,
  input  itim_req_type  itim_req,
  output itim_rsp_type  itim_rsp,
  input  itim_load_type load
);

  logic [itim_data_width-1:0] mem [itim_depth_words];

  logic [itim_index_bits-1:0] rd_index;
  logic                       rsp_ready;
  logic [itim_data_width-1:0] rsp_data;

  // word address, the low 3 bits select a byte in the block.
  assign rd_index = itim_req.addr[3 +: itim_index_bits];

  always_ff @(posedge clock) begin
    if (load.valid) begin
      mem[load.index] <= load.data;
    end
  end

  always_ff @(posedge clock) begin
    if (itim_req.valid) begin
      rsp_data <= mem[rd_index];
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      rsp_ready <= 1'b0;
    end else begin
      rsp_ready <= itim_req.valid;
    end
  end

  always_comb begin
    itim_rsp.ready = rsp_ready;
    itim_rsp.rdata = rsp_data;
  end

  // program load happens while fetch is quiet.
  load_excl: assert property (@(posedge clock) disable iff (!reset)
    !(load.valid && itim_req.valid));

endmodule

`default_nettype wire

// File: hw/csr_unit.sv
`timescale 1ns/1ns
`default_nettype none

module csr_unit import core_pkg::*; (
  input  logic            clock,
  input  logic            reset,
  input  csr_cfg_type     csr_cfg,
  input  logic            trap_req,
  input  logic            mret_req,
  input  logic [xlen-1:0] trap_pc,
  output redirect_type    redirect
);

  logic [xlen-1:0] trap_vector;
  logic [xlen-1:0] exception_pc;

  always_ff @(posedge clock) begin
    if (!reset) begin
      trap_vector <= '0;
      exception_pc <= '0;
    end else begin
      if (csr_cfg.valid) begin
        case (csr_cfg.sel)
          csr_sel_tvec: trap_vector <= csr_cfg.data;
          csr_sel_epc: exception_pc <= csr_cfg.data;
          default: ;
        endcase
      end
      // a trap overrides a config write of the same register.
      if (trap_req) begin
        exception_pc <= trap_pc;
      end
    end
  end

  always_comb begin
    redirect.trap = trap_req;
    redirect.mret = mret_req & ~trap_req;
    redirect.target = trap_req ? trap_vector : exception_pc;
  end

  trap_mret_excl: assert property (@(posedge clock) disable iff (!reset)
    !(trap_req && mret_req));

endmodule

`default_nettype wire

// File: hw/fetch_stage.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_stage import core_pkg::*, mem_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  itim_rsp_type     itim_rsp,
  output itim_req_type     itim_req,
  input  btac_out_type     btac_out,
  output logic [xlen-1:0]  lookup_pc,
  input  redirect_type     redirect,
  input  exec_resolve_type resolve,
  input  logic             credit_return,
  output fetch_packet_type packet
);

  typedef enum logic [1:0] {
    idle,
    busy,
    ctrl
  } fetch_state_type;

  fetch_state_type state, state_next;

  logic [xlen-1:0]            fetch_pc, fetch_pc_next;
  logic [xlen-1:0]            req_pc;
  logic [credit_width-1:0]    credits;
  logic                       hold_valid;
  logic [itim_data_width-1:0] hold_data;

  logic                       flush;
  logic                       rsp_live;
  logic                       src_valid;
  logic [itim_data_width-1:0] src_data;
  logic                       stall;
  logic                       emit;
  logic                       issue;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // response path and credit check.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    flush = redirect.trap | redirect.mret | (resolve.valid & resolve.mispredict);
    // responses seen in ctrl belong to the old path.
    rsp_live = itim_rsp.ready & (state == busy);
    src_valid = hold_valid | rsp_live;
    src_data = hold_valid ? hold_data : itim_rsp.rdata;
    stall = src_valid & (credits == '0);
    emit = src_valid & ~stall & ~flush;
    issue = (state != idle) & ~stall;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // next pc and state.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always_comb begin
    fetch_pc_next = fetch_pc;
    if (redirect.trap || redirect.mret) begin
      fetch_pc_next = {redirect.target[xlen-1:3], 3'b000};
    end else if (resolve.valid && resolve.mispredict) begin
      fetch_pc_next = {resolve.redirect_addr[xlen-1:3], 3'b000};
    end else if (issue && btac_out.taken) begin
      fetch_pc_next = {btac_out.target[xlen-1:3], 3'b000};
    end else if (issue) begin
      fetch_pc_next = fetch_pc + xlen'(8);
    end

    case (state)
      idle: state_next = busy;
      busy: state_next = busy;
      ctrl: state_next = busy;
      default: state_next = idle;
    endcase
    if (flush) begin
      state_next = ctrl;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      state <= idle;
      fetch_pc <= reset_pc;
      credits <= credit_width'(fetch_credits);
      hold_valid <= 1'b0;
    end else begin
      state <= state_next;
      fetch_pc <= fetch_pc_next;
      credits <= credits + credit_width'(credit_return) - credit_width'(emit);
      hold_valid <= stall & ~flush;
    end
  end

  // req_pc stays put while a response is held, since no request issues then.
  always_ff @(posedge clock) begin
    if (issue) begin
      req_pc <= fetch_pc;
    end
    if (!hold_valid) begin
      hold_data <= itim_rsp.rdata;
    end
  end

  always_comb begin
    itim_req.valid = issue;
    itim_req.addr = fetch_pc;
    lookup_pc = fetch_pc;
    packet.valid = emit;
    packet.pc = req_pc;
    packet.instr0 = src_data[31:0];
    packet.instr1 = src_data[63:32];
  end

  credit_bound: assert property (@(posedge clock) disable iff (!reset)
    credits <= credit_width'(fetch_credits));

  // decode must have room for every packet presented.
  credit_spent: assert property (@(posedge clock) disable iff (!reset)
    packet.valid |-> credits != '0);

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit import core_pkg::*, mem_pkg::*; (
  input  logic             clock,
  input  logic             reset,
  input  exec_resolve_type resolve,
  input  csr_cfg_type      csr_cfg,
  input  logic             trap_req,
  input  logic             mret_req,
  input  logic [xlen-1:0]  trap_pc,
  input  itim_load_type    load,
  input  logic             credit_return,
  output fetch_packet_type packet
);

  itim_req_type    itim_req;
  itim_rsp_type    itim_rsp;
  btac_out_type    btac_out;
  logic [xlen-1:0] lookup_pc;
  redirect_type    redirect;

  fetch_stage u_fetch_stage (
    .clock         (clock),
    .reset         (reset),
    .itim_rsp      (itim_rsp),
    .itim_req      (itim_req),
    .btac_out      (btac_out),
    .lookup_pc     (lookup_pc),
    .redirect      (redirect),
    .resolve       (resolve),
    .credit_return (credit_return),
    .packet        (packet)
  );

  btac u_btac (
    .clock     (clock),
    .reset     (reset),
    .lookup_pc (lookup_pc),
    .btac_out  (btac_out),
    .resolve   (resolve)
  );

  itim u_itim (
    .clock    (clock),
    .reset    (reset),
    .itim_req (itim_req),
    .itim_rsp (itim_rsp),
    .load     (load)
  );

  csr_unit u_csr_unit (
    .clock    (clock),
    .reset    (reset),
    .csr_cfg  (csr_cfg),
    .trap_req (trap_req),
    .mret_req (mret_req),
    .trap_pc  (trap_pc),
    .redirect (redirect)
  );

endmodule

`default_nettype wire

// File: tb/clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module clock_gen (
  output logic clock,
  output logic reset
);

  localparam int period_ns = 10;
  localparam int reset_cycles = 8;

  initial begin
    clock = 1'b0;
    forever #(period_ns / 2) clock = ~clock;
  end

  // active low, released on a falling edge.
  initial begin
    reset = 1'b0;
    repeat (reset_cycles) @(posedge clock);
    @(negedge clock);
    reset = 1'b1;
  end

endmodule

`default_nettype wire

// File: tb/fetch_unit_tb.sv
`timescale 1ns/1ns
`default_nettype none

module fetch_unit_tb import core_pkg::*, mem_pkg::*; ();

  localparam int clock_period_ns = 10;
  localparam int packet_wait_cycles = 40;
  // cycle budget per phase: load, sequential, credits, trap, mispredict, prediction.
  localparam int test_cycles = 264 + 60 + 80 + 100 + 60 + 150;
  localparam int margin_cycles = 300;
  localparam int watchdog_ns = (test_cycles + margin_cycles) * clock_period_ns;

  localparam logic [xlen-1:0] trap_vector = 32'h0000_0200;
  localparam logic [xlen-1:0] trap_origin = 32'h0000_0124;
  localparam logic [xlen-1:0] branch_pc = 32'h0000_0340;
  localparam logic [xlen-1:0] branch_target = 32'h0000_0480;
  localparam logic [xlen-1:0] other_pc = 32'h0000_0058;

  logic             clock;
  logic             por_reset;
  logic             dut_reset;
  logic             image_loaded;
  exec_resolve_type resolve;
  csr_cfg_type      csr_cfg;
  logic             trap_req;
  logic             mret_req;
  logic [xlen-1:0]  trap_pc;
  itim_load_type    load;
  logic             credit_return = 1'b0;
  fetch_packet_type packet;

  logic [itim_data_width-1:0] image [itim_depth_words];
  integer                     seed;
  fetch_packet_type           rx_q [$];
  int                         credit_due [$];
  int                         cycle = 0;
  int                         credit_delay = 1;
  logic                       credit_hold = 1'b0;
  int                         rx_count = 0;
  int                         returned_count = 0;
  int                         checks = 0;
  int                         errors = 0;
  logic [xlen-1:0]            next_pc;

  clock_gen u_clock_gen (
    .clock (clock),
    .reset (por_reset)
  );

  // reset stays asserted while the program image loads.
  assign dut_reset = por_reset & image_loaded;

  fetch_unit dut (
    .clock         (clock),
    .reset         (dut_reset),
    .resolve       (resolve),
    .csr_cfg       (csr_cfg),
    .trap_req      (trap_req),
    .mret_req      (mret_req),
    .trap_pc       (trap_pc),
    .load          (load),
    .credit_return (credit_return),
    .packet        (packet)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // decode model: collects packets, returns one credit each after a delay.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  always @(posedge clock) begin
    cycle++;
    if (!dut_reset) begin
      rx_q.delete();
      credit_due.delete();
    end else if (packet.valid) begin
      rx_q.push_back(packet);
      rx_count++;
      credit_due.push_back(cycle + credit_delay);
    end
  end

  always @(negedge clock) begin
    credit_return = 1'b0;
    if (dut_reset && !credit_hold && credit_due.size() > 0) begin
      if (credit_due[0] <= cycle) begin
        credit_return = 1'b1;
        void'(credit_due.pop_front());
        returned_count++;
      end
    end
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired after %0d ns, the tests did not finish", watchdog_ns);
    $display("checks: %0d, errors: %0d", checks, errors + 1);
    $display("TB FAILED");
    $finish;
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // compare tasks and stream helpers.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  function automatic fetch_packet_type expected_packet(input logic [xlen-1:0] pc);
    fetch_packet_type           pkt;
    logic [itim_data_width-1:0] word;
    // each 8-byte block maps to one memory word.
    word = image[pc[3 +: itim_index_bits]];
    pkt.valid = 1'b1;
    pkt.pc = pc;
    pkt.instr0 = word[31:0];
    pkt.instr1 = word[63:32];
    return pkt;
  endfunction

  task automatic check_packet(input fetch_packet_type got, input fetch_packet_type exp,
                              input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s: got pc %h instr %h %h, expected pc %h instr %h %h",
               $time, what, got.pc, got.instr0, got.instr1, exp.pc, exp.instr0, exp.instr1);
    end
  endtask

  task automatic check_pc(input logic [xlen-1:0] got, input logic [xlen-1:0] exp,
                          input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0t: %s: got pc %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic check_count(input int got, input int exp, input string what);
    checks++;
    if (got != exp) begin
      errors++;
      $display("[FAIL] %0t: %s: got %0d, expected %0d", $time, what, got, exp);
    end
  endtask

  task automatic pop_packet(output fetch_packet_type pkt);
    int waited;
    waited = 0;
    while (rx_q.size() == 0 && waited < packet_wait_cycles) begin
      @(negedge clock);
      waited++;
    end
    if (rx_q.size() == 0) begin
      errors++;
      $display("no packet arrived within %0d cycles, time %0t", packet_wait_cycles, $time);
      pkt = '0;
    end else begin
      pkt = rx_q.pop_front();
    end
  endtask

  task automatic take_packets(input int count);
    fetch_packet_type pkt;
    for (int i = 0; i < count; i++) begin
      pop_packet(pkt);
      check_packet(pkt, expected_packet(next_pc), "sequential packet");
      next_pc = next_pc + xlen'(8);
    end
  endtask

  task automatic first_packet(input string what);
    fetch_packet_type pkt;
    pop_packet(pkt);
    check_pc(pkt.pc, next_pc, what);
    check_packet(pkt, expected_packet(next_pc), what);
    next_pc = next_pc + xlen'(8);
  endtask

  // packets already seen belong to the old path, the rest start at the block of target.
  task automatic follow_redirect(input logic [xlen-1:0] target);
    fetch_packet_type pkt;
    while (rx_q.size() > 0) begin
      pkt = rx_q.pop_front();
      check_packet(pkt, expected_packet(next_pc), "packet before redirect");
      next_pc = next_pc + xlen'(8);
    end
    next_pc = {target[xlen-1:3], 3'b000};
  endtask

  task automatic send_resolve(input logic [xlen-1:0] pc, input logic taken,
                              input logic [xlen-1:0] target,
                              input logic [xlen-1:0] redirect_addr);
    @(negedge clock);
    resolve.valid = 1'b1;
    resolve.pc = pc;
    resolve.taken = taken;
    resolve.target = target;
    resolve.mispredict = 1'b1;
    resolve.redirect_addr = redirect_addr;
    follow_redirect(redirect_addr);
    @(negedge clock);
    resolve = '0;
  endtask

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // directed tests.
  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  task automatic run_sequential();
    next_pc = reset_pc;
    first_packet("first packet after reset");
    take_packets(11);
  endtask

  task automatic run_backpressure();
    int mark;
    @(negedge clock);
    credit_hold = 1'b1;
    repeat (15) @(negedge clock);
    mark = rx_count;
    repeat (15) @(negedge clock);
    check_count(rx_count - returned_count, fetch_credits, "packets held without credit");
    check_count(rx_count - mark, 0, "packets after the credits ran out");
    credit_hold = 1'b0;
    take_packets(rx_q.size() + 8);
  endtask

  task automatic run_trap_return();
    @(negedge clock);
    csr_cfg.valid = 1'b1;
    csr_cfg.sel = csr_sel_tvec;
    csr_cfg.data = trap_vector;
    @(negedge clock);
    csr_cfg = '0;
    trap_req = 1'b1;
    trap_pc = trap_origin;
    follow_redirect(trap_vector);
    @(negedge clock);
    trap_req = 1'b0;
    first_packet("first packet at the trap vector");
    take_packets(5);
    @(negedge clock);
    mret_req = 1'b1;
    follow_redirect(trap_origin);
    @(negedge clock);
    mret_req = 1'b0;
    first_packet("first packet after mret");
    take_packets(5);
  endtask

  task automatic run_mispredict();
    credit_delay = 3;
    send_resolve(other_pc, 1'b0, '0, 32'h0000_0604);
    first_packet("first packet at the mispredict target");
    take_packets(5);
    credit_delay = 1;
  endtask

  task automatic run_prediction();
    // taken branch teaches the btac and redirects.
    send_resolve(branch_pc, 1'b1, branch_target, branch_target);
    first_packet("first packet at the branch target");
    take_packets(2);
    send_resolve(other_pc, 1'b0, '0, branch_pc - xlen'(16));
    first_packet("refetch ahead of the branch");
    take_packets(2);
    next_pc = branch_target;
    first_packet("packet after the predicted branch");
    take_packets(2);
    // not taken clears the entry.
    send_resolve(branch_pc, 1'b0, '0, branch_pc - xlen'(16));
    first_packet("refetch after the not-taken resolve");
    take_packets(4);
  endtask

  initial begin
    resolve = '0;
    csr_cfg = '0;
    trap_req = 1'b0;
    mret_req = 1'b0;
    trap_pc = '0;
    load = '0;
    image_loaded = 1'b0;
    seed = 46476;
    for (int i = 0; i < itim_depth_words; i++) begin
      image[i] = {$random(seed), $random(seed)};
    end

    @(negedge clock);
    for (int i = 0; i < itim_depth_words; i++) begin
      load.valid = 1'b1;
      load.index = itim_index_bits'(i);
      load.data = image[i];
      @(negedge clock);
    end
    load = '0;
    image_loaded = 1'b1;

    run_sequential();
    run_backpressure();
    run_trap_return();
    run_mispredict();
    run_prediction();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
hw/core_pkg.sv
hw/mem_pkg.sv
hw/btac.sv
hw/itim.sv
hw/csr_unit.sv
hw/fetch_stage.sv
hw/fetch_unit.sv
tb/clock_gen.sv
tb/fetch_unit_tb.sv

// File: Bender.yml
package:
  name: fetch_unit

sources:
  - files:
      - hw/core_pkg.sv
      - hw/mem_pkg.sv
      - hw/btac.sv
      - hw/itim.sv
      - hw/csr_unit.sv
      - hw/fetch_stage.sv
      - hw/fetch_unit.sv
  - target: test
    files:
      - tb/clock_gen.sv
      - tb/fetch_unit_tb.sv
